//--- Makefile
TOP = tb_nvme_cmd_engine

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

//--- hdl/cmd_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_apb_regs
  import nvme_pkg::*;
(
  input  wire            oculink_axi_clk,
  input  wire            rstn,
  input  wire            psel,
  input  wire            penable,
  input  wire            pwrite,
  input  wire apb_addr_t paddr,
  input  wire dword_t    pwdata,
  input  wire            full,
  input  wire dword_t    cpl_count,
  input  wire dword_t    cpl_dw0,
  output dword_t         prdata,
  output logic           pready,
  output logic           pslverr,
  output logic           push,
  output sq_entry_t      push_entry
);

  logic   access;
  logic   submit_stall;
  logic   wr_done;
  logic   addr_known;
  dword_t addr_reg;
  dword_t nlb_reg;

  assign access = psel && penable;

  // a submit has to wait for a free slot
  assign submit_stall = pwrite && (paddr == REG_SUBMIT) && full;
  assign pready       = access && !submit_stall;
  assign wr_done      = access && pready && pwrite;
  assign pslverr      = access && !addr_known;

  always_comb begin
    addr_known = 1'b1;
    prdata     = '0;
    case (paddr)
      REG_ADDR:      prdata = addr_reg;
      REG_NLB:       prdata = nlb_reg;
      REG_SUBMIT:    prdata = {31'h0, full};
      REG_CPL_COUNT: prdata = cpl_count;
      REG_CPL_DW0:   prdata = cpl_dw0;
      default:       addr_known = 1'b0;
    endcase
  end

  always_ff @(posedge oculink_axi_clk or negedge rstn) begin
    if (!rstn) begin
      addr_reg <= '0;
      nlb_reg  <= '0;
      push     <= 1'b0;
    end else begin
      // push lands one cycle after the access completes
      push <= wr_done && (paddr == REG_SUBMIT);
      if (wr_done && (paddr == REG_ADDR)) begin
        addr_reg <= pwdata;
      end
      if (wr_done && (paddr == REG_NLB)) begin
        nlb_reg <= pwdata;
      end
    end
  end

  // bit 0 of the submit word selects read
  always_ff @(posedge oculink_axi_clk) begin
    if (wr_done && (paddr == REG_SUBMIT)) begin
      push_entry <= {pwdata[0], addr_reg, nlb_reg};
    end
  end

endmodule

`default_nettype wire

//--- hdl/cpl_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module cpl_receiver
  import nvme_pkg::*;
(
  input  wire         oculink_axi_clk,
  input  wire         rstn,
  input  wire dword_t cq_awaddr,
  input  wire         cq_awvalid,
  input  wire beat_t  cq_wdata,
  input  wire         cq_wlast,
  input  wire         cq_wvalid,
  input  wire         cq_bready,
  output logic        cq_awready,
  output logic        cq_wready,
  output resp_t       cq_bresp,
  output logic        cq_bvalid,
  output dword_t      cpl_count,
  output dword_t      cpl_dw0
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA,
    S_RESP
  } state_t;

  state_t state;
  logic   aw_hit;
  logic   in_win;
  logic   first_beat;
  dword_t dw0_hold;

  assign aw_hit = (cq_awaddr >= IOCQ_BASE) && (cq_awaddr < IOCQ_BASE + IOCQ_SIZE);

  assign cq_awready = (state == S_ADDR);
  assign cq_wready  = (state == S_DATA);
  assign cq_bvalid  = (state == S_RESP);
  assign cq_bresp   = in_win ? RESP_OKAY : RESP_SLVERR;

  // dword 0 of the first beat holds the command specific result
  always_ff @(posedge oculink_axi_clk) begin
    if ((state == S_DATA) && cq_wvalid && first_beat) begin
      dw0_hold <= cq_wdata[31:0];
    end
  end

  always_ff @(posedge oculink_axi_clk or negedge rstn) begin
    if (!rstn) begin
      state      <= S_IDLE;
      in_win     <= 1'b0;
      first_beat <= 1'b0;
      cpl_count  <= '0;
      cpl_dw0    <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          state <= S_ADDR;
        end
        S_ADDR: begin
          if (cq_awvalid) begin
            in_win     <= aw_hit;
            first_beat <= 1'b1;
            state      <= S_DATA;
          end
        end
        S_DATA: begin
          if (cq_wvalid) begin
            first_beat <= 1'b0;
            if (cq_wlast) begin
              state <= S_RESP;
            end
          end
        end
        S_RESP: begin
          if (cq_bready) begin
            // stray writes are answered but not counted
            if (in_win) begin
              cpl_count <= cpl_count + 1'b1;
              cpl_dw0   <= dw0_hold;
            end
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/doorbell_writer.sv
`timescale 1ns/1ps
`default_nettype none

module doorbell_writer
  import nvme_pkg::*;
(
  input  wire        oculink_axi_clk,
  input  wire        rstn,
  input  wire        ring_req,
  input  wire        db_awready,
  input  wire        db_wready,
  input  wire resp_t db_bresp,
  input  wire        db_bvalid,
  output logic       ring_ack,
  output dword_t     db_awaddr,
  output logic       db_awvalid,
  output beat_t      db_wdata,
  output strb_t      db_wstrb,
  output logic       db_wlast,
  output logic       db_wvalid,
  output logic       db_bready
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA,
    S_RESP
  } state_t;

  state_t state;
  dword_t tail;

  assign db_awaddr  = IODB_ADDR;
  assign db_awvalid = (state == S_ADDR);

  // tail copied into every dword lane, all bytes enabled
  assign db_wdata  = {8{tail}};
  assign db_wstrb  = '1;
  assign db_wvalid = (state == S_DATA);
  assign db_wlast  = (state == S_DATA);

  assign db_bready = (state == S_RESP);
  // any response ends the ring, error codes included
  assign ring_ack  = (state == S_RESP) && db_bvalid;

  always_ff @(posedge oculink_axi_clk or negedge rstn) begin
    if (!rstn) begin
      state <= S_IDLE;
      tail  <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (ring_req) begin
            tail  <= tail + 1'b1;
            state <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (db_awready) begin
            state <= S_DATA;
          end
        end
        S_DATA: begin
          if (db_wready) begin
            state <= S_RESP;
          end
        end
        S_RESP: begin
          if (db_bvalid) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/nvme_cmd_engine.sv
`timescale 1ns/1ps
`default_nettype none

module nvme_cmd_engine
  import nvme_pkg::*;
(
  input  wire            oculink_axi_clk,
  input  wire            rstn,
  // apb command port
  input  wire            psel,
  input  wire            penable,
  input  wire            pwrite,
  input  wire apb_addr_t paddr,
  input  wire dword_t    pwdata,
  output dword_t         prdata,
  output logic           pready,
  output logic           pslverr,
  // doorbell write towards the drive
  output dword_t         db_awaddr,
  output logic           db_awvalid,
  input  wire            db_awready,
  output beat_t          db_wdata,
  output strb_t          db_wstrb,
  output logic           db_wlast,
  output logic           db_wvalid,
  input  wire            db_wready,
  input  wire resp_t     db_bresp,
  input  wire            db_bvalid,
  output logic           db_bready,
  // submission entry fetch from the drive
  input  wire dword_t    sq_araddr,
  input  wire            sq_arvalid,
  output logic           sq_arready,
  output beat_t          sq_rdata,
  output logic           sq_rlast,
  output logic           sq_rvalid,
  input  wire            sq_rready,
  // completion write from the drive
  input  wire dword_t    cq_awaddr,
  input  wire            cq_awvalid,
  output logic           cq_awready,
  input  wire beat_t     cq_wdata,
  input  wire            cq_wlast,
  input  wire            cq_wvalid,
  output logic           cq_wready,
  output resp_t          cq_bresp,
  output logic           cq_bvalid,
  input  wire            cq_bready
);

  logic      push;
  sq_entry_t push_entry;
  logic      full;
  logic      pop;
  sq_entry_t pop_entry;
  logic      empty;
  logic      ring_req;
  logic      ring_ack;
  dword_t    cpl_count;
  dword_t    cpl_dw0;

  cmd_apb_regs u_regs (
    .oculink_axi_clk (oculink_axi_clk),
    .rstn            (rstn),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .full            (full),
    .cpl_count       (cpl_count),
    .cpl_dw0         (cpl_dw0),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .push            (push),
    .push_entry      (push_entry)
  );

  sq_fifo u_fifo (
    .oculink_axi_clk (oculink_axi_clk),
    .rstn            (rstn),
    .push            (push),
    .push_entry      (push_entry),
    .pop             (pop),
    .pop_entry       (pop_entry),
    .full            (full),
    .empty           (empty)
  );

  sqe_server u_server (
    .oculink_axi_clk (oculink_axi_clk),
    .rstn            (rstn),
    .empty           (empty),
    .pop_entry       (pop_entry),
    .ring_ack        (ring_ack),
    .sq_araddr       (sq_araddr),
    .sq_arvalid      (sq_arvalid),
    .sq_rready       (sq_rready),
    .pop             (pop),
    .ring_req        (ring_req),
    .sq_arready      (sq_arready),
    .sq_rdata        (sq_rdata),
    .sq_rlast        (sq_rlast),
    .sq_rvalid       (sq_rvalid)
  );

  doorbell_writer u_db (
    .oculink_axi_clk (oculink_axi_clk),
    .rstn            (rstn),
    .ring_req        (ring_req),
    .db_awready      (db_awready),
    .db_wready       (db_wready),
    .db_bresp        (db_bresp),
    .db_bvalid       (db_bvalid),
    .ring_ack        (ring_ack),
    .db_awaddr       (db_awaddr),
    .db_awvalid      (db_awvalid),
    .db_wdata        (db_wdata),
    .db_wstrb        (db_wstrb),
    .db_wlast        (db_wlast),
    .db_wvalid       (db_wvalid),
    .db_bready       (db_bready)
  );

  cpl_receiver u_cpl (
    .oculink_axi_clk (oculink_axi_clk),
    .rstn            (rstn),
    .cq_awaddr       (cq_awaddr),
    .cq_awvalid      (cq_awvalid),
    .cq_wdata        (cq_wdata),
    .cq_wlast        (cq_wlast),
    .cq_wvalid       (cq_wvalid),
    .cq_bready       (cq_bready),
    .cq_awready      (cq_awready),
    .cq_wready       (cq_wready),
    .cq_bresp        (cq_bresp),
    .cq_bvalid       (cq_bvalid),
    .cpl_count       (cpl_count),
    .cpl_dw0         (cpl_dw0)
  );

endmodule

`default_nettype wire

//--- hdl/nvme_pkg.sv
`default_nettype none

package nvme_pkg;

  // plain vector types with a meaning on the wire
  typedef logic [31:0]  dword_t;
  typedef logic [255:0] beat_t;
  typedef logic [31:0]  strb_t;
  typedef logic [1:0]   resp_t;
  typedef logic [7:0]   apb_addr_t;

  // {read flag, drive address, zero-based block count}
  typedef logic [64:0]  sq_entry_t;

  // device side address map
  localparam dword_t IODB_ADDR = 32'h8000_5008;
  localparam dword_t IOSQ_BASE = 32'h0000_B000;
  localparam dword_t IOSQ_SIZE = 32'h0000_1000;
  localparam dword_t IOCQ_BASE = 32'h0000_A000;
  localparam dword_t IOCQ_SIZE = 32'h0000_1000;

  // command fields
  localparam dword_t OPC_READ  = 32'h0000_0002;
  localparam dword_t OPC_WRITE = 32'h0000_0001;
  localparam dword_t NSID      = 32'h0000_0001;

  // pending command store
  localparam int SQ_DEPTH = 4;
  localparam int SQ_PTR_W = $clog2(SQ_DEPTH);

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // apb register map
  localparam apb_addr_t REG_ADDR      = 8'h00;
  localparam apb_addr_t REG_NLB       = 8'h04;
  localparam apb_addr_t REG_SUBMIT    = 8'h08;
  localparam apb_addr_t REG_CPL_COUNT = 8'h0C;
  localparam apb_addr_t REG_CPL_DW0   = 8'h10;

endpackage

`default_nettype wire

//--- hdl/sq_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sq_fifo
  import nvme_pkg::*;
(
  input  wire            oculink_axi_clk,
  input  wire            rstn,
  input  wire            push,
  input  wire sq_entry_t push_entry,
  input  wire            pop,
  output sq_entry_t      pop_entry,
  output logic           full,
  output logic           empty
);

  sq_entry_t             mem [SQ_DEPTH];
  logic [SQ_PTR_W-1:0]   wr_ptr;
  logic [SQ_PTR_W-1:0]   rd_ptr;
  logic [SQ_PTR_W:0]     count;
  logic                  do_push;
  logic                  do_pop;

  assign full      = (count == (SQ_PTR_W + 1)'(SQ_DEPTH));
  assign empty     = (count == '0);
  assign do_push   = push && !full;
  assign do_pop    = pop && !empty;
  // head entry is already sitting in the array
  assign pop_entry = mem[rd_ptr];

  always_ff @(posedge oculink_axi_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_entry;
    end
  end

  always_ff @(posedge oculink_axi_clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/sqe_server.sv
`timescale 1ns/1ps
`default_nettype none

module sqe_server
  import nvme_pkg::*;
(
  input  wire            oculink_axi_clk,
  input  wire            rstn,
  input  wire            empty,
  input  wire sq_entry_t pop_entry,
  input  wire            ring_ack,
  input  wire dword_t    sq_araddr,
  input  wire            sq_arvalid,
  input  wire            sq_rready,
  output logic           pop,
  output logic           ring_req,
  output logic           sq_arready,
  output beat_t          sq_rdata,
  output logic           sq_rlast,
  output logic           sq_rvalid
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_AWAIT_FETCH,
    S_BEAT0,
    S_BEAT1,
    S_FINISH
  } state_t;

  state_t state;
  logic   cur_read;
  dword_t cur_addr;
  dword_t cur_nlb;
  logic   db_acked;
  logic   ar_hit;
  dword_t opcode;
  beat_t  beat0;
  beat_t  beat1;

  assign ar_hit = (sq_araddr >= IOSQ_BASE) && (sq_araddr < IOSQ_BASE + IOSQ_SIZE);

  assign pop        = (state == S_IDLE) && !empty;
  assign sq_arready = (state == S_AWAIT_FETCH) && ar_hit;
  assign sq_rvalid  = (state == S_BEAT0) || (state == S_BEAT1);
  assign sq_rlast   = (state == S_BEAT1);

  assign opcode = cur_read ? OPC_READ : OPC_WRITE;

  // command dwords 0..7: opcode, nsid, prp1 in dw6
  assign beat0 = {32'h0, cur_addr, 32'h0, 32'h0, 32'h0, 32'h0, NSID, opcode};
  // command dwords 8..15: block count in dw12
  assign beat1 = {32'h0, 32'h0, 32'h0, cur_nlb, 32'h0, 32'h0, 32'h0, 32'h0};

  assign sq_rdata = (state == S_BEAT1) ? beat1 : beat0;

  always_ff @(posedge oculink_axi_clk) begin
    if (pop) begin
      {cur_read, cur_addr, cur_nlb} <= pop_entry;
    end
  end

  always_ff @(posedge oculink_axi_clk or negedge rstn) begin
    if (!rstn) begin
      state    <= S_IDLE;
      ring_req <= 1'b0;
      db_acked <= 1'b0;
    end else begin
      ring_req <= pop;
      // doorbell may finish before or after the fetch
      if (ring_ack) begin
        db_acked <= 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (pop) begin
            state <= S_AWAIT_FETCH;
          end
        end
        S_AWAIT_FETCH: begin
          if (sq_arvalid && sq_arready) begin
            state <= S_BEAT0;
          end
        end
        S_BEAT0: begin
          if (sq_rready) begin
            state <= S_BEAT1;
          end
        end
        S_BEAT1: begin
          if (sq_rready) begin
            state <= S_FINISH;
          end
        end
        S_FINISH: begin
          if (db_acked || ring_ack) begin
            db_acked <= 1'b0;
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src.f
hdl/nvme_pkg.sv
hdl/cmd_apb_regs.sv
hdl/sq_fifo.sv
hdl/sqe_server.sv
hdl/doorbell_writer.sv
hdl/cpl_receiver.sv
hdl/nvme_cmd_engine.sv
test/nvme_cmd_engine_asserts.sv
test/tb_nvme_cmd_engine.sv

//--- test/nvme_cmd_engine_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module nvme_cmd_engine_asserts
  import nvme_pkg::*;
(
  input wire        oculink_axi_clk,
  input wire        rstn,
  input wire        psel,
  input wire        penable,
  input wire        pready,
  input wire        pop,
  input wire        db_awvalid,
  input wire        db_awready,
  input wire        db_wvalid,
  input wire        db_wready,
  input wire beat_t db_wdata,
  input wire        sq_rvalid,
  input wire        sq_rready,
  input wire beat_t sq_rdata,
  input wire        sq_rlast,
  input wire        cq_bvalid,
  input wire        cq_bready,
  input wire resp_t cq_bresp
);

  a_db_aw_hold: assert property (@(posedge oculink_axi_clk) disable iff (!rstn)
    db_awvalid && !db_awready |=> db_awvalid)
    else $error("db_awvalid dropped before db_awready");

  a_db_w_hold: assert property (@(posedge oculink_axi_clk) disable iff (!rstn)
    db_wvalid && !db_wready |=> db_wvalid && $stable(db_wdata))
    else $error("doorbell W beat changed before db_wready");

  a_sq_r_hold: assert property (@(posedge oculink_axi_clk) disable iff (!rstn)
    sq_rvalid && !sq_rready |=> sq_rvalid && $stable(sq_rdata) && $stable(sq_rlast))
    else $error("SQ read beat changed before sq_rready");

  a_cq_b_hold: assert property (@(posedge oculink_axi_clk) disable iff (!rstn)
    cq_bvalid && !cq_bready |=> cq_bvalid && $stable(cq_bresp))
    else $error("completion response changed before cq_bready");

  // W only after the address has been taken
  a_db_w_after_aw: assert property (@(posedge oculink_axi_clk) disable iff (!rstn)
    $rose(db_wvalid) |-> $past(db_awvalid && db_awready))
    else $error("db_wvalid rose without a preceding AW handshake");

  // a stalled access is released only once the server frees a slot
  a_pready_stall: assert property (@(posedge oculink_axi_clk) disable iff (!rstn)
    psel && penable && !pready ##1 psel && penable && pready |-> $past(pop))
    else $error("pready rose in an access phase without a slot being freed");

endmodule

bind nvme_cmd_engine nvme_cmd_engine_asserts i_asserts (
  .oculink_axi_clk (oculink_axi_clk),
  .rstn            (rstn),
  .psel            (psel),
  .penable         (penable),
  .pready          (pready),
  .pop             (pop),
  .db_awvalid      (db_awvalid),
  .db_awready      (db_awready),
  .db_wvalid       (db_wvalid),
  .db_wready       (db_wready),
  .db_wdata        (db_wdata),
  .sq_rvalid       (sq_rvalid),
  .sq_rready       (sq_rready),
  .sq_rdata        (sq_rdata),
  .sq_rlast        (sq_rlast),
  .cq_bvalid       (cq_bvalid),
  .cq_bready       (cq_bready),
  .cq_bresp        (cq_bresp)
);

`default_nettype wire

//--- test/tb_nvme_cmd_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nvme_cmd_engine
  import nvme_pkg::*;
();

  // 8 in the mixed run plus 6 in the back-pressure run
  localparam int N_CMDS = 14;
  localparam int WATCHDOG_CYCLES = 200 * N_CMDS + 2000;

  logic      oculink_axi_clk;
  logic      rstn;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  dword_t    pwdata;
  dword_t    prdata;
  logic      pready;
  logic      pslverr;
  dword_t    db_awaddr;
  logic      db_awvalid;
  logic      db_awready;
  beat_t     db_wdata;
  strb_t     db_wstrb;
  logic      db_wlast;
  logic      db_wvalid;
  logic      db_wready;
  resp_t     db_bresp;
  logic      db_bvalid;
  logic      db_bready;
  dword_t    sq_araddr;
  logic      sq_arvalid;
  logic      sq_arready;
  beat_t     sq_rdata;
  logic      sq_rlast;
  logic      sq_rvalid;
  logic      sq_rready;
  dword_t    cq_awaddr;
  logic      cq_awvalid;
  logic      cq_awready;
  beat_t     cq_wdata;
  logic      cq_wlast;
  logic      cq_wvalid;
  logic      cq_wready;
  resp_t     cq_bresp;
  logic      cq_bvalid;
  logic      cq_bready;

  integer seed;
  int     checks;
  int     errors;
  int     submitted;
  int     fetched;
  int     db_checked;
  int     sqe_checked;
  logic   fetch_en;

  // expected commands in submission order
  logic   exp_rd[$];
  dword_t exp_addr[$];
  dword_t exp_nlb[$];
  // beats seen on the bus, waiting for comparison
  beat_t  db_seen[$];
  beat_t  rd_seen[$];
  logic   rd_last_seen[$];

  nvme_cmd_engine i_dut (
    .oculink_axi_clk (oculink_axi_clk),
    .rstn            (rstn),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .db_awaddr       (db_awaddr),
    .db_awvalid      (db_awvalid),
    .db_awready      (db_awready),
    .db_wdata        (db_wdata),
    .db_wstrb        (db_wstrb),
    .db_wlast        (db_wlast),
    .db_wvalid       (db_wvalid),
    .db_wready       (db_wready),
    .db_bresp        (db_bresp),
    .db_bvalid       (db_bvalid),
    .db_bready       (db_bready),
    .sq_araddr       (sq_araddr),
    .sq_arvalid      (sq_arvalid),
    .sq_arready      (sq_arready),
    .sq_rdata        (sq_rdata),
    .sq_rlast        (sq_rlast),
    .sq_rvalid       (sq_rvalid),
    .sq_rready       (sq_rready),
    .cq_awaddr       (cq_awaddr),
    .cq_awvalid      (cq_awvalid),
    .cq_awready      (cq_awready),
    .cq_wdata        (cq_wdata),
    .cq_wlast        (cq_wlast),
    .cq_wvalid       (cq_wvalid),
    .cq_wready       (cq_wready),
    .cq_bresp        (cq_bresp),
    .cq_bvalid       (cq_bvalid),
    .cq_bready       (cq_bready)
  );

  // sel 0 is the doorbell beat, 1 and 2 the two halves of a submission entry
  function automatic beat_t predict_beat(input int sel, input dword_t tail, input logic rd,
                                         input dword_t addr, input dword_t nlb);
    beat_t b;
    int    k;
    b = '0;
    case (sel)
      0: begin
        for (k = 0; k < 8; k++) begin
          b[32*k +: 32] = tail;
        end
      end
      1: begin
        b[31:0]    = rd ? OPC_READ : OPC_WRITE;
        b[63:32]   = NSID;
        b[223:192] = addr;
      end
      default: begin
        // command dword 12 is dword 4 of the second beat
        b[159:128] = nlb;
      end
    endcase
    return b;
  endfunction

  task automatic check_dword(input string name, input dword_t exp, input dword_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  // setup phase, then access phase until pready
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input dword_t wdata,
                          output dword_t rdata, output logic err);
    @(negedge oculink_axi_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge oculink_axi_clk);
    penable = 1'b1;
    #1;
    while (!pready) begin
      @(negedge oculink_axi_clk);
      #1;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge oculink_axi_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input dword_t data);
    dword_t rdata;
    logic   err;
    apb_xfer(1'b1, addr, data, rdata, err);
    check_dword($sformatf("pslverr on write to %h", addr), '0, {31'h0, err});
  endtask

  task automatic read_reg(input string name, input apb_addr_t addr, input dword_t exp);
    dword_t rdata;
    logic   err;
    apb_xfer(1'b0, addr, '0, rdata, err);
    check_dword(name, exp, rdata);
    check_dword($sformatf("pslverr on read of %h", addr), '0, {31'h0, err});
  endtask

  task automatic submit_cmd(input logic rd, input dword_t addr, input dword_t nlb);
    write_reg(REG_ADDR, addr);
    write_reg(REG_NLB, nlb);
    exp_rd.push_back(rd);
    exp_addr.push_back(addr);
    exp_nlb.push_back(nlb);
    submitted++;
    write_reg(REG_SUBMIT, {31'h0, rd});
  endtask

  // completion entry write; dword 0 of the later beats differs from the first
  task automatic cpl_write(input dword_t addr, input dword_t dw0, input int beats,
                           output resp_t resp);
    int sent;
    sent = 0;
    @(negedge oculink_axi_clk);
    cq_awaddr  = addr;
    cq_awvalid = 1'b1;
    @(posedge oculink_axi_clk);
    while (!cq_awready) @(posedge oculink_axi_clk);
    while (sent < beats) begin
      @(negedge oculink_axi_clk);
      cq_awvalid = 1'b0;
      cq_wvalid  = 1'b1;
      cq_wdata   = (sent == 0) ? {{7{~dw0}}, dw0} : {8{~dw0}};
      cq_wlast   = (sent == beats - 1);
      @(posedge oculink_axi_clk);
      while (!cq_wready) @(posedge oculink_axi_clk);
      sent++;
    end
    @(negedge oculink_axi_clk);
    cq_wvalid = 1'b0;
    cq_wlast  = 1'b0;
    cq_bready = 1'b1;
    @(posedge oculink_axi_clk);
    while (!cq_bvalid) @(posedge oculink_axi_clk);
    resp = cq_bresp;
    @(negedge oculink_axi_clk);
    cq_bready = 1'b0;
  endtask

  task automatic wait_drained();
    while ((db_checked < submitted) || (sqe_checked < submitted)) begin
      @(negedge oculink_axi_clk);
    end
    repeat (10) @(negedge oculink_axi_clk);
  endtask

  initial begin : clock_gen
    oculink_axi_clk = 1'b0;
    forever #4 oculink_axi_clk = ~oculink_axi_clk;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge oculink_axi_clk);
    $display("timeout: no progress after %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  // drive model, doorbell side, with a varying response delay
  initial begin : doorbell_responder
    int ring_no;
    ring_no   = 0;
    db_bvalid = 1'b0;
    db_bresp  = RESP_OKAY;
    forever begin
      @(posedge oculink_axi_clk);
      if (db_wvalid && db_wready) begin
        ring_no++;
        repeat (ring_no % 3) @(negedge oculink_axi_clk);
        @(negedge oculink_axi_clk);
        db_bvalid = 1'b1;
        @(posedge oculink_axi_clk);
        while (!db_bready) @(posedge oculink_axi_clk);
        @(negedge oculink_axi_clk);
        db_bvalid = 1'b0;
      end
    end
  end

  // drive model, reads one entry per submitted command
  initial begin : sq_fetcher
    int beats;
    int stall_tick;
    stall_tick = 0;
    fetched    = 0;
    sq_araddr  = '0;
    sq_arvalid = 1'b0;
    sq_rready  = 1'b0;
    forever begin
      @(negedge oculink_axi_clk);
      if (fetch_en && (fetched < submitted)) begin
        sq_araddr  = IOSQ_BASE + dword_t'((fetched % 64) * 64);
        sq_arvalid = 1'b1;
        @(posedge oculink_axi_clk);
        while (!sq_arready) @(posedge oculink_axi_clk);
        beats = 0;
        while (beats < 2) begin
          @(negedge oculink_axi_clk);
          sq_arvalid = 1'b0;
          // stall one cycle in four
          sq_rready  = ((stall_tick % 4) != 3);
          stall_tick++;
          @(posedge oculink_axi_clk);
          if (sq_rvalid && sq_rready) begin
            beats++;
          end
        end
        @(negedge oculink_axi_clk);
        sq_rready = 1'b0;
        fetched++;
      end
    end
  end

  always @(posedge oculink_axi_clk) begin : record_handshakes
    if (db_awvalid && db_awready) begin
      check_dword("doorbell address", IODB_ADDR, db_awaddr);
    end
    if (db_wvalid && db_wready) begin
      db_seen.push_back(db_wdata);
      check_dword("doorbell strobe", 32'hFFFF_FFFF, db_wstrb);
      check_dword("doorbell wlast", 32'h1, {31'h0, db_wlast});
    end
    if (sq_rvalid && sq_rready) begin
      rd_seen.push_back(sq_rdata);
      rd_last_seen.push_back(sq_rlast);
    end
  end

  initial begin : compare_beats
    beat_t  seen;
    logic   last;
    int     beat_idx;
    logic   cur_rd;
    dword_t cur_addr;
    dword_t cur_nlb;
    beat_idx    = 0;
    cur_rd      = 1'b0;
    cur_addr    = '0;
    cur_nlb     = '0;
    db_checked  = 0;
    sqe_checked = 0;
    forever begin
      @(negedge oculink_axi_clk);
      while (db_seen.size() > 0) begin
        seen = db_seen.pop_front();
        db_checked++;
        check_beat($sformatf("doorbell %0d data", db_checked),
                   predict_beat(0, dword_t'(db_checked), 1'b0, '0, '0), seen);
      end
      while (rd_seen.size() > 0) begin
        seen = rd_seen.pop_front();
        last = rd_last_seen.pop_front();
        if (beat_idx == 0) begin
          if (exp_rd.size() == 0) begin
            errors++;
            $display("submission entry fetched with no command outstanding");
          end else begin
            cur_rd   = exp_rd.pop_front();
            cur_addr = exp_addr.pop_front();
            cur_nlb  = exp_nlb.pop_front();
          end
        end
        check_beat($sformatf("entry %0d beat %0d", sqe_checked + 1, beat_idx),
                   predict_beat(beat_idx + 1, '0, cur_rd, cur_addr, cur_nlb), seen);
        check_dword($sformatf("entry %0d rlast %0d", sqe_checked + 1, beat_idx),
                    dword_t'(beat_idx), {31'h0, last});
        if (beat_idx == 1) begin
          sqe_checked++;
        end
        beat_idx = 1 - beat_idx;
      end
    end
  end

  initial begin : main_sequence
    dword_t rdata;
    logic   err;
    resp_t  resp;
    logic   rd;
    dword_t addr;
    dword_t nlb;
    dword_t exp_count;
    dword_t exp_dw0;
    int     i;
    seed       = 32'h5f14b005;
    checks     = 0;
    errors     = 0;
    submitted  = 0;
    fetch_en   = 1'b0;
    addr       = '0;
    nlb        = '0;
    rstn       = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    db_awready = 1'b0;
    db_wready  = 1'b0;
    cq_awaddr  = '0;
    cq_awvalid = 1'b0;
    cq_wdata   = '0;
    cq_wlast   = 1'b0;
    cq_wvalid  = 1'b0;
    cq_bready  = 1'b0;
    repeat (3) @(posedge oculink_axi_clk);
    @(negedge oculink_axi_clk);
    rstn       = 1'b1;
    db_awready = 1'b1;
    db_wready  = 1'b1;

    // register readback and undefined offsets
    write_reg(REG_ADDR, 32'h1234_5678);
    write_reg(REG_NLB, 32'h0000_00FF);
    read_reg("addr readback", REG_ADDR, 32'h1234_5678);
    read_reg("nlb readback", REG_NLB, 32'h0000_00FF);
    read_reg("count after reset", REG_CPL_COUNT, '0);
    apb_xfer(1'b0, 8'h14, '0, rdata, err);
    check_dword("pslverr offset 14", 32'h1, {31'h0, err});
    apb_xfer(1'b0, 8'h40, '0, rdata, err);
    check_dword("pslverr offset 40", 32'h1, {31'h0, err});

    // eight mixed commands with the drive fetching freely
    fetch_en = 1'b1;
    for (i = 0; i < 8; i++) begin
      rd   = (i % 2 == 1);
      addr = $random(seed);
      nlb  = $random(seed) & 32'h0000_FFFF;
      submit_cmd(rd, addr, nlb);
    end
    wait_drained();

    // completions inside and outside the window
    exp_count = '0;
    cpl_write(IOCQ_BASE + 32'h10, 32'hC0DE_0001, 2, resp);
    check_resp("cq write in window", RESP_OKAY, resp);
    exp_count = exp_count + 32'h1;
    exp_dw0   = 32'hC0DE_0001;
    read_reg("count after first cpl", REG_CPL_COUNT, exp_count);
    read_reg("dw0 after first cpl", REG_CPL_DW0, exp_dw0);
    cpl_write(IOCQ_BASE + 32'h20, 32'hC0DE_0002, 1, resp);
    check_resp("cq second write in window", RESP_OKAY, resp);
    exp_count = exp_count + 32'h1;
    exp_dw0   = 32'hC0DE_0002;
    read_reg("count after second cpl", REG_CPL_COUNT, exp_count);
    read_reg("dw0 after second cpl", REG_CPL_DW0, exp_dw0);
    cpl_write(32'h0000_C000, 32'hBAD0_0003, 1, resp);
    check_resp("cq write outside window", RESP_SLVERR, resp);
    cpl_write(IOCQ_BASE + IOCQ_SIZE, 32'hBAD0_0004, 1, resp);
    check_resp("cq write at window end", RESP_SLVERR, resp);
    read_reg("count after stray cpl", REG_CPL_COUNT, exp_count);
    read_reg("dw0 after stray cpl", REG_CPL_DW0, exp_dw0);

    // doorbell stalled and no fetches: one in the server, four queued
    @(negedge oculink_axi_clk);
    fetch_en   = 1'b0;
    db_awready = 1'b0;
    for (i = 0; i < 5; i++) begin
      rd   = (i % 2 == 0);
      addr = $random(seed);
      nlb  = $random(seed) & 32'h0000_FFFF;
      submit_cmd(rd, addr, nlb);
    end
    addr = $random(seed);
    nlb  = $random(seed) & 32'h0000_FFFF;
    fork
      submit_cmd(1'b1, addr, nlb);
      begin
        repeat (20) @(negedge oculink_axi_clk);
        #1;
        if (!(psel && penable && !pready)) begin
          errors++;
          $display("sixth submit was not held back while the queue was full");
        end
        @(negedge oculink_axi_clk);
        db_awready = 1'b1;
        fetch_en   = 1'b1;
      end
    join
    wait_drained();

    check_dword("doorbell writes seen", dword_t'(N_CMDS), dword_t'(db_checked));
    check_dword("entries fetched", dword_t'(N_CMDS), dword_t'(sqe_checked));
    read_reg("addr holds last value", REG_ADDR, addr);
    read_reg("nlb holds last value", REG_NLB, nlb);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
